/* design/pipePayloadPkg.sv */
/*
 * record types carried between the pipeline stages
 * and the RISC-V opcode constants used by the decoder
 */
`default_nettype none

package pipePayloadPkg;

	// register index and opcode field types
	typedef logic [4:0] regAddrT;
	typedef logic [6:0] opcodeT;

	// major opcodes the backbone cares about
	localparam opcodeT OpLoad   = 7'b0000011;
	localparam opcodeT OpStore  = 7'b0100011;
	localparam opcodeT OpBranch = 7'b1100011;

	// IF/ID payload, straight from the fetch unit
	// pred and taken come with the fetched branch
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instn;
		logic        pred;
		logic        taken;
	} fetchRec;

	// ID/EX payload, fetch fields plus decoded fields
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instn;
		logic        pred;
		logic        taken;
		regAddrT     rs1;
		regAddrT     rs2;
		// zero when the instruction writes no register
		regAddrT     rd;
		logic        isLoad;
		logic        isStore;
		logic        isBranch;
	} execRec;

	// EX/MEM and MEM/WB payload
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instn;
		regAddrT     rd;
		logic        isLoad;
		logic        isStore;
	} memRec;

endpackage : pipePayloadPkg

`default_nettype wire

/* design/pipeCtrlPkg.sv */
/*
 * hazard controller state type, wait counter width
 * and fixed stage-control levels
 */
`default_nettype none

package pipeCtrlPkg;

	// Run is normal flow, MemWait freezes the front for a memory access
	typedef enum logic {
		Run     = 1'b0,
		MemWait = 1'b1
	} ctrlState;

	// wait counter width, covers latencies 0 to 15
	localparam int LatWidth = 4;

	// levels for stage lines that no hazard ever drives
	localparam logic NoStall = 1'b0;
	localparam logic NoFlush = 1'b0;

endpackage : pipeCtrlPkg

`default_nettype wire

/* design/stageCtrlIf.sv */
/*
 * per-stage enable and clear lines with controller and stage views
 */
`timescale 1ns/1ps
`default_nettype none

interface stageCtrlIf;

	// stall lines are active-low enables, 1 holds the stage
	// stallF also serves as the fetch hold level
	logic stallF;
	logic stallD;
	logic flushD;
	logic stallE;
	logic flushE;
	logic stallM;
	logic flushW;

	// hazard controller drives every line
	modport ctrl (
		output stallF, stallD, flushD, stallE, flushE, stallM, flushW
	);

	// stage registers and fetch side only listen
	modport stages (
		input stallF, stallD, flushD, stallE, flushE, stallM, flushW
	);

endinterface : stageCtrlIf

`default_nettype wire

/* design/stageReg.sv */
/*
 * one pipeline stage register for any payload type,
 * active-low enable (stall) and synchronous clear (flush)
 */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// clear wins over enable
	// a zero record is a bubble since valid is cleared too
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (!stall) begin
			// enable low, take the next record
			q <= d;
		end
	end

endmodule : stageReg

`default_nettype wire

/* design/instrFieldDecode.sv */
/*
 * register field slicing and load/store/branch classification
 * between the IF/ID output and the ID/EX input
 */
`timescale 1ns/1ps
`default_nettype none

module instrFieldDecode import pipePayloadPkg::*; (
	input  fetchRec inRec,
	output execRec  outRec
);

	opcodeT opcode;
	logic   load;
	logic   store;
	logic   branch;

	assign opcode = inRec.instn[6:0];

	// class flags only mean something for a valid record
	assign load   = inRec.valid & (opcode == OpLoad);
	assign store  = inRec.valid & (opcode == OpStore);
	assign branch = inRec.valid & (opcode == OpBranch);

	always_comb begin
		// fetch fields pass on unchanged
		outRec.valid    = inRec.valid;
		outRec.pc       = inRec.pc;
		outRec.instn    = inRec.instn;
		outRec.pred     = inRec.pred;
		outRec.taken    = inRec.taken;
		// standard R/I/S/B field positions
		outRec.rs1      = inRec.instn[19:15];
		outRec.rs2      = inRec.instn[24:20];
		// stores and branches write nothing, so rd reads as x0
		// and the load-use compare never matches them
		outRec.rd       = (store | branch) ? '0 : inRec.instn[11:7];
		outRec.isLoad   = load;
		outRec.isStore  = store;
		outRec.isBranch = branch;
	end

endmodule : instrFieldDecode

`default_nettype wire

/* design/memWaitTimer.sv */
/*
 * down counter that times one memory access,
 * busy while counting and a done pulse on the last cycle
 */
`timescale 1ns/1ps
`default_nettype none

module memWaitTimer import pipeCtrlPkg::*; #(
	parameter int MemLatency = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic busy,
	output logic done
);

	logic [LatWidth-1:0] count;

	// load the latency on start, then count down to zero
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
		end else if (start) begin
			count <= LatWidth'(MemLatency);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// a latency of zero never raises busy
	assign busy = (count != '0);

	// last counted cycle
	assign done = (count == LatWidth'(1));

endmodule : memWaitTimer

`default_nettype wire

/* design/hazardControl.sv */
/*
 * Run/MemWait controller for load-use bubbles, memory waits
 * and branch mispredict flushes with fetch redirect
 */
`timescale 1ns/1ps
`default_nettype none

module hazardControl import pipePayloadPkg::*, pipeCtrlPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  execRec                decRec,
	input  execRec                exRec,
	input  pipePayloadPkg::memRec memRec,
	input  logic                  timerBusy,
	input  logic                  timerDone,
	output logic                  timerStart,
	output logic                  redirect,
	stageCtrlIf.ctrl              ctl
);

	ctrlState state;
	ctrlState nextState;
	logic     memAccessE;
	logic     memAccessM;
	logic     memHold;
	logic     loadUse;
	logic     mispredict;

	// memory accesses in E (about to enter MEM) and in MEM
	assign memAccessE = exRec.valid & (exRec.isLoad | exRec.isStore);
	assign memAccessM = memRec.valid & (memRec.isLoad | memRec.isStore);

	// the access in MEM is held for as long as the timer runs
	assign memHold = (state == MemWait) & timerBusy & memAccessM;

	// timer starts on the edge where the access lands in EX/MEM
	assign timerStart = memAccessE & ~memHold;

	// D reads a register that the load in E has not produced yet
	assign loadUse = exRec.valid & exRec.isLoad & (exRec.rd != '0) & decRec.valid
		& ((decRec.rs1 == exRec.rd) | (decRec.rs2 == exRec.rd));

	// branch in E resolved against its prediction
	assign mispredict = exRec.valid & exRec.isBranch & (exRec.taken != exRec.pred);

	// memory wait first, then load-use, then redirect
	// redirect only fires once the branch is free to move
	assign redirect = mispredict & ~memHold;

	always_comb begin
		// front of the pipe holds during a wait or a load-use bubble
		ctl.stallF = memHold | (loadUse & ~memHold);
		ctl.stallD = memHold | (loadUse & ~memHold);
		// drop the entry fetch presents during a redirect
		ctl.flushD = redirect;
		ctl.stallE = memHold;
		// bubble into ID/EX, or kill the wrong-path entry in D
		ctl.flushE = ~memHold & (loadUse | mispredict);
		ctl.stallM = memHold;
		// nothing leaves MEM while waiting
		ctl.flushW = memHold;
	end

	// state follows the timer; a zero latency passes straight through
	always_comb begin
		nextState = state;
		if (timerStart) begin
			nextState = MemWait;
		end else if ((state == MemWait) & (timerDone | ~timerBusy)) begin
			nextState = Run;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= Run;
		end else begin
			state <= nextState;
		end
	end

endmodule : hazardControl

`default_nettype wire

/* design/pipeBackbone.sv */
/*
 * five-stage pipeline register backbone, fetch input to retire output,
 * with stage registers, decode, memory wait timer and hazard controller
 */
`timescale 1ns/1ps
`default_nettype none

module pipeBackbone import pipePayloadPkg::*, pipeCtrlPkg::*; #(
	parameter int MemLatency = 2
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        fetchValid,
	input  logic [31:0] fetchPc,
	input  logic [31:0] fetchInstn,
	input  logic        fetchPred,
	input  logic        fetchTaken,
	output logic        fetchHold,
	output logic        redirect,
	output logic        retireValid,
	output logic [31:0] retirePc,
	output logic [31:0] retireInstn
);

	fetchRec fetchIn;
	fetchRec ifIdQ;
	execRec  decOut;
	execRec  idExQ;
	memRec   exMemD;
	memRec   exMemQ;
	memRec   memWbQ;
	logic    timerStart;
	logic    timerBusy;
	logic    timerDone;

	stageCtrlIf ctl ();

	// fetch entry as presented by the outside fetch unit
	assign fetchIn = '{valid: fetchValid, pc: fetchPc, instn: fetchInstn,
		pred: fetchPred, taken: fetchTaken};

	// fetch holds its entry whenever IF/ID is frozen
	assign fetchHold = ctl.stallF;

	stageReg #(.payloadT(fetchRec)) ifIdReg (
		.clk(clk), .reset(reset),
		.stall(ctl.stallD), .flush(ctl.flushD),
		.d(fetchIn), .q(ifIdQ)
	);

	instrFieldDecode decode (
		.inRec(ifIdQ), .outRec(decOut)
	);

	stageReg #(.payloadT(execRec)) idExReg (
		.clk(clk), .reset(reset),
		.stall(ctl.stallE), .flush(ctl.flushE),
		.d(decOut), .q(idExQ)
	);

	// branch flags are spent in E, only the memory view goes on
	assign exMemD = '{valid: idExQ.valid, pc: idExQ.pc, instn: idExQ.instn,
		rd: idExQ.rd, isLoad: idExQ.isLoad, isStore: idExQ.isStore};

	// EX/MEM is never cleared, only held
	stageReg #(.payloadT(memRec)) exMemReg (
		.clk(clk), .reset(reset),
		.stall(ctl.stallM), .flush(NoFlush),
		.d(exMemD), .q(exMemQ)
	);

	// MEM/WB always advances, bubbles come from its clear
	stageReg #(.payloadT(memRec)) memWbReg (
		.clk(clk), .reset(reset),
		.stall(NoStall), .flush(ctl.flushW),
		.d(exMemQ), .q(memWbQ)
	);

	memWaitTimer #(.MemLatency(MemLatency)) memTimer (
		.clk(clk), .reset(reset),
		.start(timerStart), .busy(timerBusy), .done(timerDone)
	);

	hazardControl hazard (
		.clk(clk), .reset(reset),
		.decRec(decOut), .exRec(idExQ), .memRec(exMemQ),
		.timerBusy(timerBusy), .timerDone(timerDone),
		.timerStart(timerStart), .redirect(redirect),
		.ctl(ctl.ctrl)
	);

	// retire stream straight off MEM/WB
	assign retireValid = memWbQ.valid;
	assign retirePc    = memWbQ.pc;
	assign retireInstn = memWbQ.instn;

endmodule : pipeBackbone

`default_nettype wire

/* test/pipeBackboneTb.sv */
/*
 * vector-driven fetch model, retire checker and compare task
 */
`timescale 1ns/1ps
`default_nettype none

module pipeBackboneTb;

	localparam int MemLatency = 2;
	localparam int MaxCycles = 2000;
	localparam int IdleLimit = 60;

	logic        clk;
	logic        reset;
	logic        fetchValid;
	logic [31:0] fetchPc;
	logic [31:0] fetchInstn;
	logic        fetchPred;
	logic        fetchTaken;
	wire         fetchHold;
	wire         redirect;
	wire         retireValid;
	wire  [31:0] retirePc;
	wire  [31:0] retireInstn;

	// fetch entries from the vector file
	logic [31:0] vecPc[$];
	logic [31:0] vecInstn[$];
	logic        vecPred[$];
	logic        vecTaken[$];
	logic        vecWrong[$];
	int          expIdx[$];
	int          acceptEdge[256];
	int          holdAtAccept[256];

	integer seed;
	int     n;
	int     ptr;
	int     retired;
	int     edgeNo;
	int     holdEdges;
	int     prevRetireEdge;
	int     prevIdx;
	int     redirects;
	int     expRedirects;
	logic   prevRedirect;

	pipeBackbone #(.MemLatency(MemLatency)) uut (
		.clk(clk), .reset(reset),
		.fetchValid(fetchValid), .fetchPc(fetchPc), .fetchInstn(fetchInstn),
		.fetchPred(fetchPred), .fetchTaken(fetchTaken),
		.fetchHold(fetchHold), .redirect(redirect),
		.retireValid(retireValid), .retirePc(retirePc), .retireInstn(retireInstn)
	);

	always #20 clk = ~clk;

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopRun("value check failed");
		end
	endtask

	// opcode classes straight from the RISC-V base encoding
	function automatic logic isMemOp(input logic [31:0] instn);
		return (instn[6:0] == 7'b0000011) || (instn[6:0] == 7'b0100011);
	endfunction

	function automatic logic isLoadUse(input logic [31:0] older, input logic [31:0] younger);
		logic [4:0] rd;
		rd = older[11:7];
		return (older[6:0] == 7'b0000011) && (rd != 5'd0)
			&& ((younger[19:15] == rd) || (younger[24:20] == rd));
	endfunction

	task automatic loadVectors();
		integer fd;
		integer code;
		reg [8*128-1:0] lineBuf;
		logic [31:0] pc;
		logic [31:0] instn;
		logic [31:0] pred;
		logic [31:0] taken;
		logic [31:0] wrong;
		fd = $fopen("test/pipeVectors.txt", "r");
		if (fd == 0) begin
			stopRun("could not open the vector file test/pipeVectors.txt");
		end
		while (!$feof(fd)) begin
			lineBuf = '0;
			code = $fgets(lineBuf, fd);
			// comment and empty lines give fewer than five fields
			code = $sscanf(lineBuf, "%h %h %h %h %h", pc, instn, pred, taken, wrong);
			if (code == 5) begin
				vecPc.push_back(pc);
				vecInstn.push_back(instn);
				vecPred.push_back(pred[0]);
				vecTaken.push_back(taken[0]);
				vecWrong.push_back(wrong[0]);
				if (!wrong[0]) begin
					expIdx.push_back(vecPc.size() - 1);
					if ((instn[6:0] == 7'b1100011) && (pred[0] != taken[0])) begin
						expRedirects++;
					end
				end
			end
		end
		$fclose(fd);
		n = vecPc.size();
	endtask

	// first half runs back to back, the rest gets random valid gaps
	task automatic presentNext();
		if ((ptr < n) && ((ptr < n / 2) || (($random(seed) & 7) != 0))) begin
			fetchValid = 1'b1;
			fetchPc    = vecPc[ptr];
			fetchInstn = vecInstn[ptr];
			fetchPred  = vecPred[ptr];
			fetchTaken = vecTaken[ptr];
		end else begin
			fetchValid = 1'b0;
		end
	endtask

	task automatic checkRetire();
		int idx;
		if (retired >= expIdx.size()) begin
			stopRun("an instruction retired beyond the expected list");
		end
		idx = expIdx[retired];
		checkValue("retirePc", retirePc, vecPc[idx]);
		checkValue("retireInstn", retireInstn, vecInstn[idx]);
		// no stall during its flight means the plain four-edge path
		if (holdEdges == holdAtAccept[idx]) begin
			checkValue("retireLatency", 32'(edgeNo - acceptEdge[idx]), 32'd3);
		end
		if (retired > 0) begin
			if (isMemOp(vecInstn[idx]) && (edgeNo - prevRetireEdge < MemLatency + 1)) begin
				stopRun("a memory access retired without waiting for the memory latency");
			end
			if (isLoadUse(vecInstn[prevIdx], vecInstn[idx])
				&& (acceptEdge[idx] == acceptEdge[prevIdx] + 1)) begin
				checkValue("loadUseGap", 32'(edgeNo - prevRetireEdge), 32'd2);
			end
		end
		prevRetireEdge = edgeNo;
		prevIdx = idx;
		retired++;
	endtask

	initial begin
		int cycles;
		int idle;
		logic wasHeld;
		clk = 1'b0;
		reset = 1'b0;
		fetchValid = 1'b0;
		fetchPc = '0;
		fetchInstn = '0;
		fetchPred = 1'b0;
		fetchTaken = 1'b0;
		seed = 32'h3944;
		ptr = 0;
		retired = 0;
		edgeNo = 0;
		holdEdges = 0;
		prevRetireEdge = 0;
		prevIdx = 0;
		redirects = 0;
		expRedirects = 0;
		prevRedirect = 1'b0;
		wasHeld = 1'b0;
		cycles = 0;
		idle = 0;
		loadVectors();

		repeat (3) @(posedge clk);
		#1 reset = 1'b1;

		// idle pipe right after reset
		repeat (2) begin
			@(negedge clk);
			checkValue("retireValid", retireValid, 1'b0);
			checkValue("fetchHold", fetchHold, 1'b0);
			checkValue("redirect", redirect, 1'b0);
		end
		@(posedge clk);
		#1 presentNext();

		while (retired < expIdx.size()) begin
			@(negedge clk);
			cycles++;
			idle++;
			if (cycles > MaxCycles) begin
				stopRun("the retire stream did not complete within the cycle limit");
			end
			if (retireValid) begin
				checkRetire();
				idle = 0;
			end
			if (idle > IdleLimit) begin
				stopRun("no instruction retired for too many cycles");
			end
			if (redirect && prevRedirect) begin
				stopRun("redirect stayed high for more than one cycle");
			end
			// what the coming edge does to the presented entry
			if (redirect) begin
				redirects++;
				if (fetchValid) begin
					ptr++;
				end
				while ((ptr < n) && vecWrong[ptr]) begin
					ptr++;
				end
			end else if (!fetchHold && fetchValid) begin
				acceptEdge[ptr] = edgeNo + 1;
				holdAtAccept[ptr] = holdEdges;
				ptr++;
			end
			if (fetchHold) begin
				holdEdges++;
			end
			prevRedirect = redirect;
			wasHeld = fetchHold;
			@(posedge clk);
			edgeNo++;
			#1;
			// a held entry stays on the bus until an edge takes it
			if (!wasHeld) begin
				presentNext();
			end
		end

		// nothing may retire after the list is complete
		fetchValid = 1'b0;
		repeat (8) begin
			@(negedge clk);
			if (retireValid) begin
				stopRun("an instruction retired beyond the expected list");
			end
		end
		checkValue("redirectCount", redirects, expRedirects);
		$display("Test passed");
		$finish;
	end

endmodule : pipeBackboneTb

`default_nettype wire

/* test/pipeVectors.txt */
# pc instn pred taken wrongPath (all hex)
# wrongPath 1 marks entries fetched after a mispredicted branch, they never retire
00000000 007302b3 0 0 0
00000004 00a48433 0 0 0
00000008 00d605b3 0 0 0
0000000c 00012183 0 0 0
00000010 00518233 0 0 0
00000014 00a48433 0 0 0
00000018 00412223 0 0 0
0000001c 007302b3 0 0 0
00000020 00208863 0 1 0
00000024 00a48433 0 0 1
00000028 00d605b3 0 0 1
00000030 00012183 0 0 0
00000034 00518233 0 0 0
00000038 00012183 0 0 0
0000003c 00012183 0 0 0
00000040 00208863 1 1 0
00000050 007302b3 0 0 0
00000054 00208863 1 0 0
00000064 00a48433 0 0 1
00000068 00d605b3 0 0 1
00000058 00412223 0 0 0
0000005c 00518233 0 0 0
00000060 007302b3 0 0 0
00000064 00012183 0 0 0
00000068 00518233 0 0 0
0000006c 00a48433 0 0 0
00000070 00208863 0 1 0
00000074 007302b3 0 0 1
00000078 00a48433 0 0 1
00000080 00d605b3 0 0 0

/* pipeBackbone.f */
design/pipePayloadPkg.sv
design/pipeCtrlPkg.sv
design/stageCtrlIf.sv
design/stageReg.sv
design/instrFieldDecode.sv
design/memWaitTimer.sv
design/hazardControl.sv
design/pipeBackbone.sv
test/pipeBackboneTb.sv

/* Bender.yml */
package:
  name: pipeBackbone

sources:
  # packages first, then the RTL in dependency order
  - design/pipePayloadPkg.sv
  - design/pipeCtrlPkg.sv
  - design/stageCtrlIf.sv
  - design/stageReg.sv
  - design/instrFieldDecode.sv
  - design/memWaitTimer.sv
  - design/hazardControl.sv
  - design/pipeBackbone.sv
  - target: test
    files:
      - test/pipeBackboneTb.sv
